// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W     = 32;
    localparam int WAYS       = 2;
    localparam int SETS       = 64;
    localparam int LINE_WORDS = 8;
    localparam int WORD_W     = 32;
    localparam int BE_W       = WORD_W / 8;
    localparam int INDEX_W    = 6;
    localparam int BANK_W     = 3;
    localparam int OFFSET_W   = 2;
    // what is left of the address after index, bank and byte offset
    localparam int TAG_W      = ADDR_W - INDEX_W - BANK_W - OFFSET_W;

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [BANK_W-1:0]   bank;
        logic [OFFSET_W-1:0] offset;
    } addr_t;

    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    // wen all zero means a load
    typedef struct packed {
        logic              en;
        logic [BE_W-1:0]   wen;
        addr_t             addr;
        logic [WORD_W-1:0] wdata;
    } req_t;

    typedef struct packed {
        logic              valid;
        logic              hit;
        logic [WORD_W-1:0] rdata;
    } resp_t;

    // line fill request plus the victim that the fill replaces
    typedef struct packed {
        logic             rreq;
        addr_t            addr;
        logic             victim_dirty;
        logic [TAG_W-1:0] victim_tag;
        line_t            victim_line;
    } miss_t;

    typedef struct packed {
        logic                  en;
        logic                  way;
        logic [INDEX_W-1:0]    index;
        logic [LINE_WORDS-1:0] bank_mask;
        logic [BE_W-1:0]       be;
        logic [TAG_W-1:0]      tag;
        logic                  tag_we;
        line_t                 data;
    } wr_cmd_t;

    typedef struct packed {
        logic              valid;
        logic              is_load;
        logic              is_store;
        logic [BE_W-1:0]   wen;
        addr_t             addr;
        logic [WORD_W-1:0] wdata;
    } stage_t;

endpackage

// ==== hw/dcache_sram.sv ====
module dcache_sram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 64
) (
    input  logic                       clk,
    input  logic [(WIDTH+7)/8-1:0]     we_i,
    input  logic [$clog2(DEPTH)-1:0]   waddr_i,
    input  logic [WIDTH-1:0]           wdata_i,
    input  logic [$clog2(DEPTH)-1:0]   raddr_i,
    output logic [WIDTH-1:0]           rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    // one enable per byte, last byte may be partial
    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (we_i[i/8]) begin
                mem[waddr_i][i] <= wdata_i[i];
            end
        end
    end

    // write-first: a same-address read sees the new bytes
    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (we_i[i/8] && (raddr_i == waddr_i)) begin
                rdata_o[i] <= wdata_i[i];
            end else begin
                rdata_o[i] <= mem[raddr_i][i];
            end
        end
    end

endmodule

// ==== hw/dcache_req_stage.sv ====
module dcache_req_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  dcache_pkg::req_t                 req_i,
    input  logic                             stall_i,
    input  logic                             busy_i,
    output logic                             ready_o,
    output logic [dcache_pkg::INDEX_W-1:0]   rd_index_o,
    output dcache_pkg::stage_t               stage_o
);

    import dcache_pkg::*;

    logic              valid_q;
    logic              load_q;
    logic              store_q;
    logic [BE_W-1:0]   wen_q;
    addr_t             addr_q;
    logic [WORD_W-1:0] wdata_q;

    assign ready_o = ~(stall_i | busy_i);

    // request flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            load_q  <= 1'b0;
            store_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= req_i.en;
            load_q  <= req_i.en & ~(|req_i.wen);
            store_q <= req_i.en & (|req_i.wen);
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (ready_o) begin
            wen_q   <= req_i.wen;
            addr_q  <= req_i.addr;
            wdata_q <= req_i.wdata;
        end
    end

    // keep the RAM reading the held set while frozen,
    // so tags and data line up with the request in the register
    assign rd_index_o = ready_o ? req_i.addr.index : addr_q.index;

    always_comb begin
        stage_o          = '0;
        stage_o.valid    = valid_q;
        stage_o.is_load  = load_q;
        stage_o.is_store = store_q;
        stage_o.wen      = wen_q;
        stage_o.addr     = addr_q;
        stage_o.wdata    = wdata_q;
    end

endmodule

// ==== hw/dcache_ways.sv ====
module dcache_ways #(
    parameter int DEPTH      = 64,
    parameter int TAG_RAM_W  = 21,
    parameter int DATA_RAM_W = 32
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [dcache_pkg::INDEX_W-1:0]                       rd_index_i,
    input  dcache_pkg::wr_cmd_t                                  wr_cmd_i,
    input  logic [dcache_pkg::INDEX_W-1:0]                       meta_index_i,
    input  logic                                                 hit_way_i,
    input  logic                                                 write_hit_i,
    input  logic                                                 refill_i,
    output logic [dcache_pkg::WAYS-1:0][dcache_pkg::TAG_W-1:0]   tag_o,
    output logic [dcache_pkg::WAYS-1:0]                          valid_o,
    output logic [dcache_pkg::WAYS-1:0]                          dirty_o,
    output logic                                                 lru_o,
    output dcache_pkg::line_t [dcache_pkg::WAYS-1:0]             line_o
);

    import dcache_pkg::*;

    localparam int TAG_BE_W  = (TAG_RAM_W + 7) / 8;
    localparam int DATA_BE_W = (DATA_RAM_W + 7) / 8;

    logic [WAYS-1:0][DEPTH-1:0] valid_q;
    logic [WAYS-1:0][DEPTH-1:0] valid_d;
    logic [WAYS-1:0][DEPTH-1:0] dirty_q;
    logic [WAYS-1:0][DEPTH-1:0] dirty_d;
    // per set: the way to replace next
    logic [DEPTH-1:0]           lru_q;
    logic [DEPTH-1:0]           lru_d;

    //////////////////////////////////////////////////////////////////////
    // tag and data RAMs
    //////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic way_sel;

        assign way_sel = wr_cmd_i.en && (int'(wr_cmd_i.way) == w);

        dcache_sram #(.WIDTH(TAG_RAM_W), .DEPTH(DEPTH)) u_tag (
            .clk     (clk),
            .we_i    ({TAG_BE_W{way_sel & wr_cmd_i.tag_we}}),
            .waddr_i (wr_cmd_i.index),
            .wdata_i (wr_cmd_i.tag),
            .raddr_i (rd_index_i),
            .rdata_o (tag_o[w])
        );

        // one bank per word of the line
        for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
            dcache_sram #(.WIDTH(DATA_RAM_W), .DEPTH(DEPTH)) u_data (
                .clk     (clk),
                .we_i    ({DATA_BE_W{way_sel & wr_cmd_i.bank_mask[b]}} & wr_cmd_i.be),
                .waddr_i (wr_cmd_i.index),
                .wdata_i (wr_cmd_i.data[b]),
                .raddr_i (rd_index_i),
                .rdata_o (line_o[w][b])
            );
        end
    end

    //////////////////////////////////////////////////////////////////////
    // valid, dirty and LRU bits
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        valid_d = valid_q;
        dirty_d = dirty_q;
        lru_d   = lru_q;
        if (refill_i) begin
            valid_d[wr_cmd_i.way][meta_index_i] = 1'b1;
            dirty_d[wr_cmd_i.way][meta_index_i] = 1'b0;
            lru_d[meta_index_i]                 = ~wr_cmd_i.way;
        end else if (write_hit_i) begin
            dirty_d[hit_way_i][meta_index_i] = 1'b1;
            lru_d[meta_index_i]              = ~hit_way_i;
        end
    end

    // read from the next values, same as the RAMs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
            valid_o <= '0;
            dirty_o <= '0;
            lru_o   <= 1'b0;
        end else begin
            valid_q <= valid_d;
            dirty_q <= dirty_d;
            lru_q   <= lru_d;
            for (int w = 0; w < WAYS; w++) begin
                valid_o[w] <= valid_d[w][rd_index_i];
                dirty_o[w] <= dirty_d[w][rd_index_i];
            end
            lru_o <= lru_d[rd_index_i];
        end
    end

endmodule

// ==== hw/dcache_lookup.sv ====
module dcache_lookup (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  dcache_pkg::stage_t                                   stage_i,
    input  logic                                                 stall_i,
    input  logic [dcache_pkg::WAYS-1:0][dcache_pkg::TAG_W-1:0]   tag_i,
    input  logic [dcache_pkg::WAYS-1:0]                          valid_i,
    input  logic [dcache_pkg::WAYS-1:0]                          dirty_i,
    input  logic                                                 lru_i,
    input  dcache_pkg::line_t [dcache_pkg::WAYS-1:0]             line_i,
    input  logic                                                 refill_valid_i,
    input  dcache_pkg::line_t                                    refill_line_i,
    output dcache_pkg::resp_t                                    resp_o,
    output dcache_pkg::miss_t                                    miss_o,
    output dcache_pkg::wr_cmd_t                                  wr_cmd_o,
    output logic [dcache_pkg::INDEX_W-1:0]                       meta_index_o,
    output logic                                                 hit_way_o,
    output logic                                                 write_hit_o,
    output logic                                                 refill_o,
    output logic                                                 busy_o
);

    import dcache_pkg::*;

    // lookup, wait for refill, answer after refill, answered but held
    localparam logic [1:0] S_LOOKUP = 2'd0;
    localparam logic [1:0] S_MISS   = 2'd1;
    localparam logic [1:0] S_FILLED = 2'd2;
    localparam logic [1:0] S_HELD   = 2'd3;

    logic [1:0]        state_q;
    logic [1:0]        state_d;
    logic [WAYS-1:0]   hit_vec;
    logic              hit;
    logic              hit_way;
    logic [WORD_W-1:0] hit_word;
    logic              missing;
    line_t             fill_line;

    function automatic logic [WORD_W-1:0] merge_word(input logic [WORD_W-1:0] old_w,
                                                     input logic [WORD_W-1:0] new_w,
                                                     input logic [BE_W-1:0]   be);
        logic [WORD_W-1:0] res;
        res = old_w;
        for (int i = 0; i < BE_W; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_i[w] && (tag_i[w] == stage_i.addr.tag);
        end
    end

    assign hit      = |hit_vec;
    // two ways, so the upper match bit names the way
    assign hit_way  = hit_vec[1];
    assign hit_word = line_i[hit_way][stage_i.addr.bank];
    assign missing  = (state_q == S_MISS) ||
                      ((state_q == S_LOOKUP) && stage_i.valid && !hit);

    // store miss bytes go into the refilled word
    always_comb begin
        fill_line = refill_line_i;
        fill_line[stage_i.addr.bank] = merge_word(refill_line_i[stage_i.addr.bank],
                                                  stage_i.wdata, stage_i.wen);
    end

    assign meta_index_o = stage_i.addr.index;
    assign hit_way_o    = hit_way;

    always_comb begin
        state_d      = state_q;
        resp_o       = '0;
        wr_cmd_o     = '0;
        write_hit_o  = 1'b0;
        refill_o     = 1'b0;
        busy_o       = 1'b0;
        wr_cmd_o.index = stage_i.addr.index;
        wr_cmd_o.tag   = stage_i.addr.tag;

        miss_o              = '0;
        miss_o.addr.tag     = stage_i.addr.tag;
        miss_o.addr.index   = stage_i.addr.index;
        miss_o.victim_dirty = dirty_i[lru_i];
        miss_o.victim_tag   = tag_i[lru_i];
        miss_o.victim_line  = line_i[lru_i];

        case (state_q)
            S_LOOKUP: begin
                if (stage_i.valid && hit) begin
                    resp_o.valid = 1'b1;
                    resp_o.hit   = 1'b1;
                    resp_o.rdata = stage_i.is_load ? hit_word :
                                   merge_word(hit_word, stage_i.wdata, stage_i.wen);
                    if (stage_i.is_store) begin
                        wr_cmd_o.en        = 1'b1;
                        wr_cmd_o.way       = hit_way;
                        wr_cmd_o.bank_mask = LINE_WORDS'(1) << stage_i.addr.bank;
                        wr_cmd_o.be        = stage_i.wen;
                        wr_cmd_o.data      = {LINE_WORDS{stage_i.wdata}};
                        write_hit_o        = 1'b1;
                    end
                    state_d = stall_i ? S_HELD : S_LOOKUP;
                end
            end
            S_FILLED: begin
                // tags now match the filled way, hit flag stays low
                resp_o.valid = 1'b1;
                resp_o.rdata = hit_word;
                state_d      = stall_i ? S_HELD : S_LOOKUP;
            end
            S_HELD: begin
                state_d = stall_i ? S_HELD : S_LOOKUP;
            end
            default: ;
        endcase

        if (missing) begin
            miss_o.rreq = 1'b1;
            busy_o      = 1'b1;
            state_d     = S_MISS;
            if (refill_valid_i) begin
                wr_cmd_o.en        = 1'b1;
                wr_cmd_o.way       = lru_i;
                wr_cmd_o.bank_mask = '1;
                wr_cmd_o.be        = '1;
                wr_cmd_o.tag_we    = 1'b1;
                wr_cmd_o.data      = fill_line;
                refill_o           = 1'b1;
                state_d            = S_FILLED;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== hw/dcache_top.sv ====
module dcache_top (
    input  logic                clk,
    input  logic                rst_n,
    input  dcache_pkg::req_t    req_i,
    input  logic                stall_i,
    input  logic                refill_valid_i,
    input  dcache_pkg::line_t   refill_line_i,
    output logic                ready_o,
    output dcache_pkg::resp_t   resp_o,
    output dcache_pkg::miss_t   miss_o
);

    import dcache_pkg::*;

    stage_t                         stage;
    logic [INDEX_W-1:0]             rd_index;
    wr_cmd_t                        wr_cmd;
    logic [INDEX_W-1:0]             meta_index;
    logic                           hit_way;
    logic                           write_hit;
    logic                           refill;
    logic                           busy;
    logic [WAYS-1:0][TAG_W-1:0]     way_tag;
    logic [WAYS-1:0]                way_valid;
    logic [WAYS-1:0]                way_dirty;
    logic                           way_lru;
    line_t [WAYS-1:0]               way_line;

    dcache_req_stage u_req_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .stall_i    (stall_i),
        .busy_i     (busy),
        .ready_o    (ready_o),
        .rd_index_o (rd_index),
        .stage_o    (stage)
    );

    dcache_ways #(
        .DEPTH      (SETS),
        .TAG_RAM_W  (TAG_W),
        .DATA_RAM_W (WORD_W)
    ) u_ways (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_index_i   (rd_index),
        .wr_cmd_i     (wr_cmd),
        .meta_index_i (meta_index),
        .hit_way_i    (hit_way),
        .write_hit_i  (write_hit),
        .refill_i     (refill),
        .tag_o        (way_tag),
        .valid_o      (way_valid),
        .dirty_o      (way_dirty),
        .lru_o        (way_lru),
        .line_o       (way_line)
    );

    dcache_lookup u_lookup (
        .clk            (clk),
        .rst_n          (rst_n),
        .stage_i        (stage),
        .stall_i        (stall_i),
        .tag_i          (way_tag),
        .valid_i        (way_valid),
        .dirty_i        (way_dirty),
        .lru_i          (way_lru),
        .line_i         (way_line),
        .refill_valid_i (refill_valid_i),
        .refill_line_i  (refill_line_i),
        .resp_o         (resp_o),
        .miss_o         (miss_o),
        .wr_cmd_o       (wr_cmd),
        .meta_index_o   (meta_index),
        .hit_way_o      (hit_way),
        .write_hit_o    (write_hit),
        .refill_o       (refill),
        .busy_o         (busy)
    );

endmodule

// ==== tb/dcache_sva.sv ====
module dcache_sva (
    input logic               clk,
    input logic               rst_n,
    input dcache_pkg::req_t   req_i,
    input logic               ready_o,
    input dcache_pkg::resp_t  resp_o,
    input dcache_pkg::miss_t  miss_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // a response and a fill request never share a cycle
    resp_excludes_miss: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(resp_o.valid && miss_o.rreq)
    ) else $error("response valid while a line fill is requested");

    // no new request while the line fill is outstanding
    ready_low_on_miss: assert property (
        @(posedge clk) disable iff (!rst_n)
        miss_o.rreq |-> !ready_o
    ) else $error("ready high while a line fill is requested");

    // upstream holds a refused request
    req_held_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_i.en && !ready_o) |=> $stable(req_i)
    ) else $error("request changed while it was not accepted");

endmodule

bind dcache_top dcache_sva u_sva (.*);

// ==== tb/dcache_tb.sv ====
module dcache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    localparam int WAIT_LIMIT = 50;

    typedef struct packed {
        logic              hit;
        logic [WORD_W-1:0] rdata;
        logic              victim_valid;
        logic              victim_dirty;
        logic [TAG_W-1:0]  victim_tag;
        line_t             victim_line;
    } exp_t;

    logic  clk = 1'b0;
    logic  rst_n;
    req_t  req_i;
    logic  stall_i;
    logic  refill_valid_i;
    line_t refill_line_i;
    logic  ready_o;
    resp_t resp_o;
    miss_t miss_o;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    exp_t   exp_q [$];

    // cache model and backing memory
    logic [TAG_W-1:0]  m_tag   [WAYS][SETS];
    logic              m_valid [WAYS][SETS];
    logic              m_dirty [WAYS][SETS];
    logic              m_lru   [SETS];
    line_t             m_line  [WAYS][SETS];
    logic [WORD_W-1:0] mem_model [logic [ADDR_W-1:0]];

    dcache_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_i          (req_i),
        .stall_i        (stall_i),
        .refill_valid_i (refill_valid_i),
        .refill_line_i  (refill_line_i),
        .ready_o        (ready_o),
        .resp_o         (resp_o),
        .miss_o         (miss_o)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [WORD_W-1:0] fill_pattern(input logic [ADDR_W-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
    endfunction

    function automatic logic [WORD_W-1:0] mem_read(input logic [ADDR_W-1:0] a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return fill_pattern(a);
    endfunction

    function automatic logic [WORD_W-1:0] apply_byte_enables(input logic [WORD_W-1:0] old_w,
                                                             input logic [WORD_W-1:0] new_w,
                                                             input logic [BE_W-1:0]   be);
        logic [WORD_W-1:0] res;
        res = old_w;
        for (int i = 0; i < BE_W; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // expected answer of one access, model state moves along with it
    function automatic exp_t predict(input addr_t a, input logic [BE_W-1:0] wen,
                                     input logic [WORD_W-1:0] wdata);
        exp_t               e;
        logic               way;
        logic [INDEX_W-1:0] idx;
        addr_t              wa;
        e   = '0;
        idx = a.index;
        way = m_lru[idx];
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[w][idx] && (m_tag[w][idx] == a.tag)) begin
                e.hit = 1'b1;
                way   = w[0];
            end
        end
        if (e.hit) begin
            e.rdata = m_line[way][idx][a.bank];
            if (wen != '0) begin
                e.rdata                    = apply_byte_enables(e.rdata, wdata, wen);
                m_line[way][idx][a.bank]   = e.rdata;
                m_dirty[way][idx]          = 1'b1;
                m_lru[idx]                 = ~way;
            end
        end else begin
            e.victim_valid = m_valid[way][idx];
            e.victim_dirty = m_dirty[way][idx];
            e.victim_tag   = m_tag[way][idx];
            e.victim_line  = m_line[way][idx];
            for (int bb = 0; bb < LINE_WORDS; bb++) begin
                wa        = a;
                wa.bank   = bb[BANK_W-1:0];
                wa.offset = '0;
                m_line[way][idx][bb] = mem_read(wa);
            end
            e.rdata = apply_byte_enables(m_line[way][idx][a.bank], wdata, wen);
            m_line[way][idx][a.bank] = e.rdata;
            m_tag[way][idx]   = a.tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
            m_lru[idx]        = ~way;
        end
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // response checker
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : compare_responses
        exp_t e;
        if (rst_n && resp_o.valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("response arrived with no access outstanding");
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                checks++;
                assert (resp_o.hit == e.hit) else begin
                    errors++;
                    $display("Error: resp_o.hit got %h expected %h", resp_o.hit, e.hit);
                end
                assert (resp_o.rdata == e.rdata) else begin
                    errors++;
                    $display("Error: resp_o.rdata got %h expected %h", resp_o.rdata, e.rdata);
                end
            end
        end
    end

    // line fills, one to four cycles late, dirty victims written back
    initial begin : memory_model
        addr_t              wa;
        line_t              fill;
        int                 delay;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        refill_valid_i = 1'b0;
        refill_line_i  = '0;
        forever begin
            @(posedge clk);
            if (rst_n && miss_o.rreq) begin
                idx = miss_o.addr.index;
                tag = miss_o.addr.tag;
                if (miss_o.victim_dirty) begin
                    for (int bb = 0; bb < LINE_WORDS; bb++) begin
                        wa = {miss_o.victim_tag, idx, bb[BANK_W-1:0], 2'b00};
                        mem_model[wa] = miss_o.victim_line[bb];
                    end
                end
                delay = {$random(seed)} % 4 + 1;
                repeat (delay) @(negedge clk);
                for (int bb = 0; bb < LINE_WORDS; bb++) begin
                    wa = {tag, idx, bb[BANK_W-1:0], 2'b00};
                    fill[bb] = mem_read(wa);
                end
                refill_line_i  = fill;
                refill_valid_i = 1'b1;
                @(posedge clk);
                checks++;
                assert (miss_o.rreq) else begin
                    errors++;
                    $display("fill request dropped before the refill arrived");
                end
                @(negedge clk);
                refill_valid_i = 1'b0;
                @(posedge clk);
                checks++;
                assert (resp_o.valid && !resp_o.hit && ready_o) else begin
                    errors++;
                    $display("no miss response with ready in the cycle after the refill");
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("checks: %0d  errors: %0d", checks, errors + 1);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic drive_req(input addr_t a, input logic [BE_W-1:0] wen,
                             input logic [WORD_W-1:0] wdata);
        req_i.en    = 1'b1;
        req_i.addr  = a;
        req_i.wen   = wen;
        req_i.wdata = wdata;
    endtask

    task automatic wait_accept();
        int t;
        t = 0;
        @(posedge clk);
        while (!ready_o) begin
            t++;
            if (t > WAIT_LIMIT) begin
                abort_run("request was never accepted");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            t++;
            if (t > WAIT_LIMIT) begin
                abort_run("expected response never arrived");
            end
            @(negedge clk);
        end
    endtask

    task automatic do_access(input addr_t a, input logic [BE_W-1:0] wen,
                             input logic [WORD_W-1:0] wdata);
        exp_t  e;
        addr_t la;
        // line address of the access
        la        = a;
        la.bank   = '0;
        la.offset = '0;
        e = predict(a, wen, wdata);
        exp_q.push_back(e);
        drive_req(a, wen, wdata);
        wait_accept();
        @(negedge clk);
        req_i.en = 1'b0;
        @(posedge clk);
        checks++;
        if (e.hit) begin
            assert (resp_o.valid && resp_o.hit) else begin
                errors++;
                $display("hit response missing one cycle after acceptance");
            end
        end else begin
            assert (miss_o.rreq) else begin
                errors++;
                $display("fill request did not rise one cycle after acceptance");
            end
            assert (miss_o.addr == la) else begin
                errors++;
                $display("Error: miss_o.addr got %h expected %h", miss_o.addr, la);
            end
            assert (miss_o.victim_dirty == e.victim_dirty) else begin
                errors++;
                $display("Error: miss_o.victim_dirty got %h expected %h",
                         miss_o.victim_dirty, e.victim_dirty);
            end
            if (e.victim_valid) begin
                assert (miss_o.victim_tag == e.victim_tag) else begin
                    errors++;
                    $display("Error: miss_o.victim_tag got %h expected %h",
                             miss_o.victim_tag, e.victim_tag);
                end
                assert (miss_o.victim_line == e.victim_line) else begin
                    errors++;
                    $display("Error: miss_o.victim_line got %h expected %h",
                             miss_o.victim_line, e.victim_line);
                end
            end
        end
        wait_drained();
    endtask

    initial begin : stimulus
        logic [31:0]     r;
        addr_t           addr_a;
        addr_t           addr_x;
        addr_t           addr_d;
        exp_t            e;
        logic [BE_W-1:0] wen;
        seed    = 32'h5f62_469c;
        rst_n   = 1'b0;
        stall_i = 1'b0;
        req_i   = '0;
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end
        for (int s = 0; s < SETS; s++) begin
            m_lru[s] = 1'b0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        checks++;
        assert (!resp_o.valid && !miss_o.rreq && ready_o) else begin
            errors++;
            $display("outputs not idle after reset");
        end
        @(negedge clk);

        // first load misses, second word of the line hits
        r = $random(seed);
        addr_a = r;
        addr_a.offset = '0;
        do_access(addr_a, 4'h0, 32'h0);
        addr_x = addr_a;
        addr_x.bank = addr_a.bank + 3'd1;
        do_access(addr_x, 4'h0, 32'h0);

        // partial store hit then load back
        r = $random(seed);
        do_access(addr_a, 4'b0110, r);
        do_access(addr_a, 4'h0, 32'h0);

        // three lines in one set, the dirty line is evicted
        addr_x = addr_a;
        addr_x.tag = addr_a.tag ^ TAG_W'(1);
        do_access(addr_x, 4'h0, 32'h0);
        addr_x.tag = addr_a.tag ^ TAG_W'(2);
        do_access(addr_x, 4'h0, 32'h0);

        // store miss, then load hit with merged word
        r = $random(seed);
        addr_d = r;
        addr_d.offset = '0;
        addr_d.index = addr_a.index + 6'd1;
        r = $random(seed);
        do_access(addr_d, 4'b1001, r);
        do_access(addr_d, 4'h0, 32'h0);
        // evicted line comes back from memory
        do_access(addr_a, 4'h0, 32'h0);

        // response under stall, next request held
        e = predict(addr_d, 4'h0, 32'h0);
        exp_q.push_back(e);
        drive_req(addr_d, 4'h0, 32'h0);
        wait_accept();
        @(negedge clk);
        stall_i = 1'b1;
        addr_x = addr_d;
        addr_x.bank = addr_d.bank ^ 3'd5;
        e = predict(addr_x, 4'h0, 32'h0);
        exp_q.push_back(e);
        drive_req(addr_x, 4'h0, 32'h0);
        @(posedge clk);
        checks++;
        assert (resp_o.valid && !ready_o) else begin
            errors++;
            $display("pending response not presented while stalled");
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            checks++;
            assert (!resp_o.valid && !ready_o) else begin
                errors++;
                $display("response repeated or ready high while stalled");
            end
        end
        @(negedge clk);
        stall_i = 1'b0;
        wait_accept();
        @(negedge clk);
        req_i.en = 1'b0;
        wait_drained();

        // random mix over two sets and four tags
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            addr_x = addr_a;
            addr_x.tag = addr_a.tag ^ TAG_W'(r[1:0]);
            addr_x.index = addr_a.index + {5'd0, r[2]};
            addr_x.bank = r[7:5];
            wen = r[4] ? r[11:8] : 4'h0;
            r = $random(seed);
            do_access(addr_x, wen, r);
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/dcache_pkg.sv
hw/dcache_sram.sv
hw/dcache_req_stage.sv
hw/dcache_ways.sv
hw/dcache_lookup.sv
hw/dcache_top.sv
tb/dcache_sva.sv
tb/dcache_tb.sv

// ==== Makefile ====
TOP := dcache_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f
	verilator --lint-only -Wall --top-module dcache_top hw/dcache_pkg.sv hw/dcache_sram.sv \
		hw/dcache_req_stage.sv hw/dcache_ways.sv hw/dcache_lookup.sv hw/dcache_top.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f \
		-Mdir $(OBJ) -o dcache_sim
	./$(OBJ)/dcache_sim 2>&1 | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
